//--- raster.f
verilog/raster_geom_pkg.sv
verilog/raster_tile_pkg.sv
verilog/raster_ifs.sv
verilog/raster_bounds.sv
verilog/raster_edges.sv
verilog/raster_coarse.sv
verilog/raster_fine.sv
verilog/raster_top.sv
tb/raster_checker.sv
tb/raster_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module raster_tb \
	-f raster.f \
	-o raster_sim

./obj_dir/raster_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
	exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

//--- tb/raster_checker.sv
module raster_checker (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   geom_tready,
	input logic                   cov_tvalid,
	input raster_geom_pkg::word_t cov_tdata,
	input logic                   cov_tlast,
	input logic                   cov_tready
);

	// A word offered on the output stays put until it is taken
	a_cov_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cov_tvalid && !cov_tready |=> cov_tvalid && $stable(cov_tdata))
		else $error("cov_tvalid or cov_tdata changed while cov_tready was low");

	a_last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		cov_tlast |-> cov_tvalid)
		else $error("cov_tlast high without cov_tvalid");

	// First cycle out of reset
	a_reset_state: assert property (@(posedge clk)
		$rose(rst_n) |-> geom_tready && !cov_tvalid)
		else $error("geom_tready low or cov_tvalid high right after reset");

endmodule

//--- tb/raster_tb.sv
module raster_tb;

	import raster_geom_pkg::*;

	localparam int PASSES = 2;
	localparam int MEM_WORDS = 256;

	logic clk;
	logic rst_n;
	logic geom_tvalid;
	word_t geom_tdata;
	logic geom_tlast;
	logic geom_tready;
	logic cov_tvalid;
	word_t cov_tdata;
	logic cov_tlast;
	logic cov_tready;
	logic stall_on;

	word_t vec_mem [MEM_WORDS];
	word_t tri_words [$];
	word_t exp_words [$];
	logic exp_lasts [$];
	word_t pend_data [$];
	logic pend_last [$];
	word_t exp_d;
	logic exp_l;
	int n_tri;
	int n_pkt;
	int errors;
	int words_checked;
	int cycle_count;
	int cycle_limit = 100000;

	raster_top #(
		.TILE_BITS(2)
	) i_raster_top (
		.clk(clk),
		.rst_n(rst_n),
		.geom_tvalid(geom_tvalid),
		.geom_tdata(geom_tdata),
		.geom_tlast(geom_tlast),
		.geom_tready(geom_tready),
		.cov_tvalid(cov_tvalid),
		.cov_tdata(cov_tdata),
		.cov_tlast(cov_tlast),
		.cov_tready(cov_tready)
	);

	bind raster_top raster_checker i_checker (
		.clk(clk),
		.rst_n(rst_n),
		.geom_tready(geom_tready),
		.cov_tvalid(cov_tvalid),
		.cov_tdata(cov_tdata),
		.cov_tlast(cov_tlast),
		.cov_tready(cov_tready)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Each packet expands to id, position and mask, with tlast on the mask
	task automatic load_vectors();
		int pos;
		int npk;
		int t;
		int w;
		int k;
		$readmemh("tb/raster_vectors.txt", vec_mem);
		if ($isunknown(vec_mem[0])) begin
			$display("Vector file holds no triangle count");
			errors++;
			return;
		end
		n_tri = int'(vec_mem[0]);
		pos = 1;
		for (t = 0; t < n_tri; t++) begin
			if (pos + 7 >= MEM_WORDS || $isunknown(vec_mem[pos + 7])) begin
				$display("Vector file ends inside triangle %0d", t);
				errors++;
				return;
			end
			for (w = 0; w < 7; w++)
				tri_words.push_back(vec_mem[pos + w]);
			npk = int'(vec_mem[pos + 7]);
			for (k = 0; k < npk; k++) begin
				exp_words.push_back(vec_mem[pos]);
				exp_words.push_back(vec_mem[pos + 8 + 2 * k]);
				exp_words.push_back(vec_mem[pos + 9 + 2 * k]);
				exp_lasts.push_back(1'b0);
				exp_lasts.push_back(1'b0);
				exp_lasts.push_back(1'b1);
			end
			n_pkt += npk;
			pos += 8 + 2 * npk;
		end
	endtask

	task automatic send_word(word_t data, logic last, logic gaps);
		while (gaps && ($urandom % 4) == 0) begin
			geom_tvalid <= 1'b0;
			@(posedge clk);
		end
		geom_tvalid <= 1'b1;
		geom_tdata <= data;
		geom_tlast <= last;
		@(posedge clk);
		while (!geom_tready)
			@(posedge clk);
	endtask

	task automatic send_all(logic gaps);
		int i;
		for (i = 0; i < tri_words.size(); i++)
			send_word(tri_words[i], (i % 7) == 6, gaps);
		geom_tvalid <= 1'b0;
		geom_tlast <= 1'b0;
	endtask

	task automatic check_idle();
		if (cov_tvalid !== 1'b0) begin
			errors++;
			$display("FAIL cov_tvalid after reset: expected %h, got %h", 1'b0, cov_tvalid);
		end
		if (geom_tready !== 1'b1) begin
			errors++;
			$display("FAIL geom_tready after reset: expected %h, got %h", 1'b1, geom_tready);
		end
	endtask

	always @(posedge clk) begin
		if (stall_on)
			cov_tready <= ($urandom % 3) != 0;
		else
			cov_tready <= 1'b1;
	end

	always @(posedge clk) begin
		if (rst_n && cov_tvalid && cov_tready) begin
			if (pend_data.size() == 0) begin
				errors++;
				$display("Output word %h arrived with no packet left to expect", cov_tdata);
			end else begin
				exp_d = pend_data.pop_front();
				exp_l = pend_last.pop_front();
				words_checked++;
				if (cov_tdata !== exp_d) begin
					errors++;
					$display("FAIL cov_tdata: expected %h, got %h", exp_d, cov_tdata);
				end
				if (cov_tlast !== exp_l) begin
					errors++;
					$display("FAIL cov_tlast: expected %h, got %h", exp_l, cov_tlast);
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with %0d words still missing", cycle_count,
			pend_data.size());
		$display("Errors: %0d, words checked: %0d", errors + 1, words_checked);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		geom_tvalid = 1'b0;
		geom_tdata = '0;
		geom_tlast = 1'b0;
		cov_tready = 1'b0;
		stall_on = 1'b0;
		errors = 0;
		words_checked = 0;
		n_pkt = 0;
		void'($urandom(32'h9107));
		load_vectors();
		cycle_limit = PASSES * (200 * n_tri + 40 * n_pkt) + 100;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_idle();

		// Second pass repeats the stream under input gaps and output stalls
		for (int pass = 0; pass < PASSES; pass++) begin
			stall_on <= (pass == 1);
			foreach (exp_words[i]) begin
				pend_data.push_back(exp_words[i]);
				pend_last.push_back(exp_lasts[i]);
			end
			send_all(pass == 1);
			while (pend_data.size() != 0)
				@(posedge clk);
		end

		stall_on <= 1'b0;
		repeat (40) @(posedge clk);

		$display("Errors: %0d, words checked: %0d", errors, words_checked);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- tb/raster_vectors.txt
// Triangle: id ax bx cx ay by cy packet_count, coordinates 16-bit signed in 32-bit words
// Packet: position {y, x} and coverage mask, tiles in row-major order
00000005
// Small triangle inside the tile at (8, 4)
00000011 00000009 0000000b 00000009 00000005 00000005 00000007 00000001
00040008 000026e0
// Spans 4 x 3 tiles around the origin, three tiles come out empty
00000022 fffffffa 00000005 fffffffa fffffffd fffffffd 00000006 00000009
fffcfff8 0000ccc0
fffcfffc 0000fff0
fffc0000 00007ff0
fffc0004 00000030
0000fff8 0000cccc
0000fffc 000037ff
00000000 00000013
0004fff8 000004cc
0004fffc 00000001
// Wound the other way
00000033 00000001 00000001 00000003 00000001 00000003 00000001 00000000
// Collinear, every edge is zero on the line through the vertices
00000044 00000005 00000006 00000007 00000001 00000002 00000003 00000001
00000004 00008421
00000055 00000002 00000005 00000002 00000000 00000000 00000003 00000002
00000000 00004ccc
00000004 00000013

//--- verilog/raster_bounds.sv
module raster_bounds #(
	parameter int TILE_BITS = 2
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   geom_tvalid,
	input  raster_geom_pkg::word_t geom_tdata,
	input  logic                   geom_tlast,
	output logic                   geom_tready,
	tri_setup_if.src               setup
);

	import raster_geom_pkg::*;

	typedef enum logic [1:0] {
		IN_ID,
		IN_X,
		IN_Y
	} in_state_t;

	in_state_t in_state;
	logic [1:0] vtx_sel;
	logic geom_hs, tri_done, complete, launch, s1_valid;
	word_t id_in, s1_id;
	coord_t in_x [3];
	coord_t in_y [3];
	tri_vtx_t s1_vtx;
	// Bit 0 is a < b, bit 1 is a < c, bit 2 is b < c
	logic [2:0] lt_x, lt_y;
	coord_t min_x, max_x, min_y, max_y;

	function automatic coord_t lowest(coord_t a, coord_t b, coord_t c, logic [2:0] lt);
		if (lt[0])
			return lt[1] ? a : c;
		return lt[2] ? b : c;
	endfunction

	function automatic coord_t highest(coord_t a, coord_t b, coord_t c, logic [2:0] lt);
		if (lt[0])
			return lt[2] ? c : b;
		return lt[1] ? c : a;
	endfunction

	assign geom_hs = geom_tvalid & geom_tready;
	assign tri_done = geom_hs & (in_state == IN_Y) & (vtx_sel == 2'd2);
	// The pipeline only starts when the output slot is free by the time it lands
	assign launch = complete & ~s1_valid & (~setup.valid | setup.ready);
	assign geom_tready = ~complete | launch;

	assign min_x = lowest(s1_vtx.a.x, s1_vtx.b.x, s1_vtx.c.x, lt_x);
	assign max_x = highest(s1_vtx.a.x, s1_vtx.b.x, s1_vtx.c.x, lt_x);
	assign min_y = lowest(s1_vtx.a.y, s1_vtx.b.y, s1_vtx.c.y, lt_y);
	assign max_y = highest(s1_vtx.a.y, s1_vtx.b.y, s1_vtx.c.y, lt_y);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_state <= IN_ID;
			vtx_sel <= 2'd0;
			complete <= 1'b0;
			s1_valid <= 1'b0;
			setup.valid <= 1'b0;
		end else begin
			if (geom_hs) begin
				unique case (in_state)
					IN_ID: in_state <= IN_X;
					default: begin
						vtx_sel <= (vtx_sel == 2'd2) ? 2'd0 : vtx_sel + 2'd1;
						if (vtx_sel == 2'd2)
							in_state <= (in_state == IN_X) ? IN_Y : IN_ID;
					end
				endcase
			end
			complete <= (complete & ~launch) | tri_done;
			s1_valid <= launch;
			if (s1_valid)
				setup.valid <= 1'b1;
			else if (setup.ready)
				setup.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (geom_hs && in_state == IN_ID)
			id_in <= geom_tdata;
		if (geom_hs && in_state == IN_X)
			in_x[vtx_sel] <= coord_t'(geom_tdata[15:0]);
		if (geom_hs && in_state == IN_Y)
			in_y[vtx_sel] <= coord_t'(geom_tdata[15:0]);

		if (launch) begin
			s1_id <= id_in;
			s1_vtx <= '{a: '{y: in_y[0], x: in_x[0]},
			            b: '{y: in_y[1], x: in_x[1]},
			            c: '{y: in_y[2], x: in_x[2]}};
			lt_x <= {in_x[1] < in_x[2], in_x[0] < in_x[2], in_x[0] < in_x[1]};
			lt_y <= {in_y[1] < in_y[2], in_y[0] < in_y[2], in_y[0] < in_y[1]};
		end

		if (s1_valid) begin
			setup.id <= s1_id;
			setup.vtx <= s1_vtx;
			setup.bbox.min_x <= coord_t'((min_x >>> TILE_BITS) <<< TILE_BITS);
			setup.bbox.min_y <= coord_t'((min_y >>> TILE_BITS) <<< TILE_BITS);
			setup.bbox.span_x <= 16'((max_x >>> TILE_BITS) - (min_x >>> TILE_BITS));
			setup.bbox.span_y <= 16'((max_y >>> TILE_BITS) - (min_y >>> TILE_BITS));
		end
	end

	// tlast comes with the seventh word and only there
	a_tlast_on_last_word: assert property (@(posedge clk) disable iff (!rst_n)
		geom_hs |-> geom_tlast == (in_state == IN_Y && vtx_sel == 2'd2));

endmodule

//--- verilog/raster_coarse.sv
module raster_coarse #(
	parameter int TILE_BITS = raster_tile_pkg::TILE_BITS_DEFAULT
) (
	input  logic      clk,
	input  logic      rst_n,
	edge_setup_if.dst edges,
	tile_if.src       tiles
);

	import raster_geom_pkg::*;
	import raster_tile_pkg::*;

	localparam int SIDE = tile_side(TILE_BITS);

	typedef enum logic [1:0] {
		C_IDLE,
		C_TEST,
		C_OUT
	} state_t;

	state_t state;
	edge_idx_t idx;
	logic ok, ok_all, ok_now, full_now, last_x, last_tile, advance;
	logic [2:0] full;
	logic [15:0] tx, ty, span_x, span_y;
	coord_t min_x;
	edge_set_t cur;
	edge_val_t row_val [3];
	edge_val_t sx, sy, ex, ey, hi, lo;

	assign edges.ready = state == C_IDLE;
	assign tiles.valid = state == C_OUT;
	assign tiles.corner = cur;
	assign tiles.steps = full;

	// Corner offsets of the edge under test, largest and smallest value
	assign sx = cur[idx].step_x;
	assign sy = cur[idx].step_y;
	assign ex = sx * edge_val_t'(SIDE - 1);
	assign ey = sy * edge_val_t'(SIDE - 1);
	assign hi = cur[idx].origin + (sx > 0 ? ex : edge_val_t'(0)) + (sy > 0 ? ey : edge_val_t'(0));
	assign lo = cur[idx].origin + (sx < 0 ? ex : edge_val_t'(0)) + (sy < 0 ? ey : edge_val_t'(0));
	assign ok_now = ~hi[31];
	assign full_now = ~lo[31];
	assign ok_all = (ok | (idx == EDGE_AB)) & ok_now;

	assign last_x = tx == span_x;
	assign last_tile = last_x & (ty == span_y);
	assign advance = (state == C_OUT && tiles.ready)
		|| (state == C_TEST && idx == EDGE_CA && !ok_all);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= C_IDLE;
			idx <= EDGE_AB;
		end else begin
			unique case (state)
				C_IDLE:
					if (edges.valid) begin
						state <= C_TEST;
						idx <= EDGE_AB;
					end
				C_TEST:
					if (idx != EDGE_CA)
						idx <= idx + 2'd1;
					else if (ok_all)
						state <= C_OUT;
				default: ;
			endcase
			if (advance) begin
				state <= last_tile ? C_IDLE : C_TEST;
				idx <= EDGE_AB;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (edges.valid && edges.ready) begin
			tiles.id <= edges.id;
			tiles.pos <= '{y: edges.bbox.min_y, x: edges.bbox.min_x};
			min_x <= edges.bbox.min_x;
			span_x <= edges.bbox.span_x;
			span_y <= edges.bbox.span_y;
			tx <= 16'd0;
			ty <= 16'd0;
			cur <= edges.edges;
			for (int e = 0; e < 3; e++)
				row_val[e] <= edges.edges[e].origin;
		end

		if (state == C_TEST) begin
			ok <= ok_all;
			full[idx] <= full_now;
		end

		if (advance) begin
			if (last_x) begin
				tx <= 16'd0;
				ty <= ty + 16'd1;
				tiles.pos.x <= min_x;
				tiles.pos.y <= tiles.pos.y + coord_t'(SIDE);
				for (int e = 0; e < 3; e++) begin
					row_val[e] <= row_val[e] + cur[e].step_y * edge_val_t'(SIDE);
					cur[e].origin <= row_val[e] + cur[e].step_y * edge_val_t'(SIDE);
				end
			end else begin
				tx <= tx + 16'd1;
				tiles.pos.x <= tiles.pos.x + coord_t'(SIDE);
				for (int e = 0; e < 3; e++)
					cur[e].origin <= cur[e].origin + cur[e].step_x * edge_val_t'(SIDE);
			end
		end
	end

endmodule

//--- verilog/raster_edges.sv
module raster_edges (
	input  logic      clk,
	input  logic      rst_n,
	tri_setup_if.dst  setup,
	edge_setup_if.src edges
);

	import raster_geom_pkg::*;

	typedef enum logic [1:0] {
		E_IDLE,
		E_CALC,
		E_DONE
	} state_t;

	state_t state;
	edge_idx_t idx;
	tri_vtx_t vtx;
	vertex_t p, q;
	edge_val_t step_x, step_y, origin;

	assign setup.ready = state == E_IDLE;
	assign edges.valid = state == E_DONE;

	always_comb begin
		unique case (idx)
			EDGE_BC: begin
				p = vtx.b;
				q = vtx.c;
			end
			EDGE_CA: begin
				p = vtx.c;
				q = vtx.a;
			end
			default: begin
				p = vtx.a;
				q = vtx.b;
			end
		endcase
	end

	assign step_x = edge_val_t'(p.y) - edge_val_t'(q.y);
	assign step_y = edge_val_t'(q.x) - edge_val_t'(p.x);
	// Edge function evaluated at the box origin
	assign origin = step_x * (edge_val_t'(edges.bbox.min_x) - edge_val_t'(q.x))
		+ step_y * (edge_val_t'(edges.bbox.min_y) - edge_val_t'(q.y));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= E_IDLE;
			idx <= EDGE_AB;
		end else begin
			unique case (state)
				E_IDLE:
					if (setup.valid) begin
						state <= E_CALC;
						idx <= EDGE_AB;
					end
				E_CALC:
					if (idx == EDGE_CA)
						state <= E_DONE;
					else
						idx <= idx + 2'd1;
				default:
					if (edges.ready)
						state <= E_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (setup.valid && setup.ready) begin
			vtx <= setup.vtx;
			edges.id <= setup.id;
			edges.bbox <= setup.bbox;
		end
		if (state == E_CALC) begin
			edges.edges[idx].step_x <= step_x;
			edges.edges[idx].step_y <= step_y;
			edges.edges[idx].origin <= origin;
		end
	end

endmodule

//--- verilog/raster_fine.sv
module raster_fine #(
	parameter int TILE_BITS = raster_tile_pkg::TILE_BITS_DEFAULT
) (
	input  logic                   clk,
	input  logic                   rst_n,
	tile_if.dst                    tiles,
	output logic                   cov_tvalid,
	output raster_geom_pkg::word_t cov_tdata,
	output logic                   cov_tlast,
	input  logic                   cov_tready
);

	import raster_geom_pkg::*;
	import raster_tile_pkg::*;

	localparam int SIDE = tile_side(TILE_BITS);

	typedef enum logic [1:0] {
		F_IDLE,
		F_EVAL,
		F_SEND
	} state_t;

	state_t state;
	cov_kind_t kind;
	word_t id;
	vertex_t pos;
	edge_set_t corner;
	logic [2:0] full;
	tile_mask_t mask, mask_now;

	assign tiles.ready = state == F_IDLE;
	assign cov_tvalid = state == F_SEND;
	assign cov_tlast = cov_tvalid & (kind == COV_MASK);

	always_comb begin
		unique case (kind)
			COV_POS: cov_tdata = pos_word(pos.x, pos.y);
			COV_MASK: cov_tdata = mask_word(mask);
			default: cov_tdata = id;
		endcase
	end

	// Every pixel of the tile against all three edges at once
	always_comb begin
		edge_val_t val;
		logic hit;
		mask_now = '0;
		for (int r = 0; r < SIDE; r++) begin
			for (int c = 0; c < SIDE; c++) begin
				hit = 1'b1;
				for (int e = 0; e < 3; e++) begin
					val = corner[e].origin + edge_val_t'(c) * corner[e].step_x
						+ edge_val_t'(r) * corner[e].step_y;
					hit = hit & (full[e] | ~val[31]);
				end
				mask_now[r * SIDE + c] = hit;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= F_IDLE;
			kind <= COV_ID;
		end else begin
			unique case (state)
				F_IDLE:
					if (tiles.valid)
						state <= F_EVAL;
				F_EVAL: begin
					kind <= COV_ID;
					state <= (mask_now != '0) ? F_SEND : F_IDLE;
				end
				default:
					if (cov_tready) begin
						unique case (kind)
							COV_ID: kind <= COV_POS;
							COV_POS: kind <= COV_MASK;
							default: state <= F_IDLE;
						endcase
					end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (tiles.valid && tiles.ready) begin
			id <= tiles.id;
			pos <= tiles.pos;
			corner <= tiles.corner;
			full <= tiles.steps;
		end
		if (state == F_EVAL)
			mask <= mask_now;
	end

endmodule

//--- verilog/raster_geom_pkg.sv
package raster_geom_pkg;

	typedef logic [31:0] word_t;

	// Whole pixels, signed
	typedef logic signed [15:0] coord_t;

	// Packed with y on top so a vertex reads as {y, x} in a stream word
	typedef struct packed {
		coord_t y;
		coord_t x;
	} vertex_t;

	typedef struct packed {
		vertex_t a;
		vertex_t b;
		vertex_t c;
	} tri_vtx_t;

	// Origin is tile aligned, spans count tiles minus one
	typedef struct packed {
		coord_t      min_x;
		coord_t      min_y;
		logic [15:0] span_x;
		logic [15:0] span_y;
	} bbox_t;

	typedef logic signed [31:0] edge_val_t;

	typedef struct packed {
		edge_val_t step_x;
		edge_val_t step_y;
		edge_val_t origin;
	} edge_t;

	typedef edge_t [2:0] edge_set_t;

	typedef logic [1:0] edge_idx_t;

	localparam edge_idx_t EDGE_AB = 2'd0;
	localparam edge_idx_t EDGE_BC = 2'd1;
	localparam edge_idx_t EDGE_CA = 2'd2;

endpackage

//--- verilog/raster_ifs.sv
interface tri_setup_if;

	import raster_geom_pkg::*;

	logic     valid;
	logic     ready;
	word_t    id;
	tri_vtx_t vtx;
	bbox_t    bbox;

	modport src (output valid, id, vtx, bbox, input ready);
	modport dst (input valid, id, vtx, bbox, output ready);

endinterface

interface edge_setup_if;

	import raster_geom_pkg::*;

	logic      valid;
	logic      ready;
	word_t     id;
	bbox_t     bbox;
	edge_set_t edges;

	modport src (output valid, id, bbox, edges, input ready);
	modport dst (input valid, id, bbox, edges, output ready);

endinterface

interface tile_if;

	import raster_geom_pkg::*;

	logic      valid;
	logic      ready;
	word_t     id;
	vertex_t   pos;
	// Edge values at the tile origin, per-pixel steps alongside
	edge_set_t corner;
	// Edges that hold for the whole tile and need no per-pixel test
	logic [2:0] steps;

	modport src (output valid, id, pos, corner, steps, input ready);
	modport dst (input valid, id, pos, corner, steps, output ready);

endinterface

//--- verilog/raster_tile_pkg.sv
package raster_tile_pkg;

	localparam int TILE_BITS_DEFAULT = 2;

	// Bit row * side + column, small tiles leave the upper bits clear
	typedef logic [15:0] tile_mask_t;

	typedef enum logic [1:0] {
		COV_ID,
		COV_POS,
		COV_MASK
	} cov_kind_t;

	function automatic int tile_side(int bits);
		return 1 << bits;
	endfunction

	function automatic logic [31:0] pos_word(logic [15:0] x, logic [15:0] y);
		return {y, x};
	endfunction

	function automatic logic [31:0] mask_word(tile_mask_t mask);
		return {16'd0, mask};
	endfunction

endpackage

//--- verilog/raster_top.sv
module raster_top #(
	parameter int TILE_BITS = raster_tile_pkg::TILE_BITS_DEFAULT
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   geom_tvalid,
	input  raster_geom_pkg::word_t geom_tdata,
	input  logic                   geom_tlast,
	output logic                   geom_tready,
	output logic                   cov_tvalid,
	output raster_geom_pkg::word_t cov_tdata,
	output logic                   cov_tlast,
	input  logic                   cov_tready
);

	import raster_tile_pkg::*;

	// A tile must fit the coverage mask
	if (TILE_BITS < 1 || tile_side(TILE_BITS) * tile_side(TILE_BITS) > $bits(tile_mask_t))
	begin : g_tile_check
		$error("TILE_BITS out of range for the coverage mask");
	end

	tri_setup_if  setup_link ();
	edge_setup_if edge_link ();
	tile_if       tile_link ();

	raster_bounds #(
		.TILE_BITS(TILE_BITS)
	) i_bounds (
		.clk,
		.rst_n,
		.geom_tvalid,
		.geom_tdata,
		.geom_tlast,
		.geom_tready,
		.setup(setup_link.src)
	);

	raster_edges i_edges (
		.clk,
		.rst_n,
		.setup(setup_link.dst),
		.edges(edge_link.src)
	);

	raster_coarse #(
		.TILE_BITS(TILE_BITS)
	) i_coarse (
		.clk,
		.rst_n,
		.edges(edge_link.dst),
		.tiles(tile_link.src)
	);

	raster_fine #(
		.TILE_BITS(TILE_BITS)
	) i_fine (
		.clk,
		.rst_n,
		.tiles(tile_link.dst),
		.cov_tvalid,
		.cov_tdata,
		.cov_tlast,
		.cov_tready
	);

endmodule
